/* compile.f */
source/flush_cfg_pkg.sv
source/flush_mem_pkg.sv
source/line_data_ram.sv
source/req_meta_fifo.sv
source/beat_resizer.sv
source/flush_ctrl.sv
source/flush_unit_top.sv
sim/flush_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the flush unit testbench with Verilator, run it, and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module flush_tb -o flush_tb_sim \
    && ./obj_dir/flush_tb_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null

grep -q "STATUS: PASS" sim.log && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }

/* sim/flush_tb.sv */
`timescale 1ns/1ns

module flush_tb
    import flush_cfg_pkg::*;
    import flush_mem_pkg::*;
;

    localparam int unsigned n_entries  = 4;
    localparam int unsigned flit_depth = 2;
    localparam int unsigned n_ids      = 2 ** mem_id_width;
    localparam int unsigned n_basic    = 16;
    localparam int unsigned n_bp       = 48;
    localparam int unsigned n_flushes  = n_basic + n_entries + 1 + n_bp;
    localparam int unsigned watchdog_cycles = n_flushes * 40 + 2000;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    fill_t      fill_i;
    logic       alloc_i;
    nline_t     alloc_nline_i;
    way_vec_t   alloc_way_i;
    logic       alloc_ready_o;
    nline_t     check_nline_i;
    logic       check_hit_o;
    logic       empty_o;
    logic       full_o;
    logic       busy_o;
    logic       ack_o;
    nline_t     ack_nline_o;
    logic       mem_req_valid_o;
    logic       mem_req_ready_i;
    mem_req_t   mem_req_o;
    logic       mem_wdata_valid_o;
    logic       mem_wdata_ready_i;
    mem_wdata_t mem_wdata_o;
    logic       mem_resp_valid_i;
    mem_resp_t  mem_resp_i;

    // Reference model state
    logic [31:0]  lfsr_q;
    access_data_t mem_copy [n_sets][n_ways][beats_per_line];
    nline_t       pend_line [$];
    mem_data_t    exp_fdata [$];
    logic         exp_flast [$];
    int unsigned  resp_q [$];
    logic         out_valid [n_ids];
    nline_t       out_line [n_ids];
    nline_t       hist [8];
    logic [2:0]   hist_ptr = '0;
    mem_req_t     held_req;
    mem_wdata_t   held_flit;

    int  out_cnt = 0;
    int  flushes_left = 0;
    int  lines_accepted = 0;
    int  lines_sent = 0;
    int  lines_last = 0;
    int  busy_run = 0;
    int  beats_left = 0;
    int  errors = 0;
    int  checks = 0;
    int  tests = 0;
    bit  accept_prev = 1'b0;
    bit  req_hold = 1'b0;
    bit  flit_hold = 1'b0;
    bit  mon_en = 1'b0;
    bit  drive_en = 1'b0;
    bit  bp_en = 1'b0;
    bit  resp_en = 1'b0;
    int  req_left = 0;
    int  wd_left = 0;

    flush_unit_top #(
        .n_entries  (n_entries),
        .flit_depth (flit_depth)
    ) i_flush_unit_top (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .fill_i            (fill_i),
        .alloc_i           (alloc_i),
        .alloc_nline_i     (alloc_nline_i),
        .alloc_way_i       (alloc_way_i),
        .alloc_ready_o     (alloc_ready_o),
        .check_nline_i     (check_nline_i),
        .check_hit_o       (check_hit_o),
        .empty_o           (empty_o),
        .full_o            (full_o),
        .busy_o            (busy_o),
        .ack_o             (ack_o),
        .ack_nline_o       (ack_nline_o),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .mem_req_o         (mem_req_o),
        .mem_wdata_valid_o (mem_wdata_valid_o),
        .mem_wdata_ready_i (mem_wdata_ready_i),
        .mem_wdata_o       (mem_wdata_o),
        .mem_resp_valid_i  (mem_resp_valid_i),
        .mem_resp_i        (mem_resp_i)
    );

    always #10 clk_i = ~clk_i;

    // Galois LFSR, one step per bit
    function automatic bit next_bit();
        bit b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // Wide enough for a whole data flit with its last flag
    task automatic expect_equal(input string name,
                                input logic [$bits(mem_wdata_t)-1:0] got,
                                input logic [$bits(mem_wdata_t)-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int n, input int start);
        tests++;
        $display("test %-14s done: %0d flushes, %0d errors", name, n, errors - start);
    endtask

    task automatic wait_drained();
        do begin
            @(posedge clk_i);
        end while (flushes_left > 0 || pend_line.size() > 0 || exp_fdata.size() > 0 ||
                   lines_sent != lines_accepted || out_cnt > 0 || resp_q.size() > 0);
    endtask

    task automatic run_flushes(input string name, input int n, input bit bp);
        int start;
        start = errors;
        @(posedge clk_i);
        bp_en = bp;
        resp_en = 1'b1;
        flushes_left = n;
        wait_drained();
        @(negedge clk_i);
        check_true(empty_o, "empty_o low after all writes were acknowledged");
        report_test(name, n, start);
    endtask

    // Stimulus, applied shortly after each rising edge
    always @(posedge clk_i) begin : driver
        int unsigned pick;
        #2;
        if (drive_en) begin
            alloc_i = (flushes_left > 0) && (rand_bits(2) != 0);
            alloc_nline_i = nline_t'(rand_bits(12));
            alloc_way_i = next_bit() ? 2'b10 : 2'b01;
            if (next_bit() && lines_accepted > 0) begin
                check_nline_i = hist[rand_bits(3)];
            end else begin
                check_nline_i = nline_t'(rand_bits(12));
            end
            if (bp_en) begin
                // Long random stretches of ready high or low
                if (req_left == 0) begin
                    mem_req_ready_i = next_bit();
                    req_left = rand_bits(5) + 1;
                end
                if (wd_left == 0) begin
                    mem_wdata_ready_i = next_bit();
                    wd_left = rand_bits(5) + 1;
                end
                req_left--;
                wd_left--;
            end else begin
                mem_req_ready_i = 1'b1;
                mem_wdata_ready_i = 1'b1;
            end
            mem_resp_valid_i = 1'b0;
            if (resp_en && resp_q.size() > 0 && next_bit()) begin
                pick = rand_bits(3) % resp_q.size();
                mem_resp_i.id = resp_q[pick][mem_id_width-1:0];
                resp_q.delete(pick);
                mem_resp_valid_i = 1'b1;
            end
        end
    end

    // Observes settled outputs in the middle of each cycle
    always @(negedge clk_i) begin : monitor
        logic        exp_hit;
        int          occ;
        int unsigned rid;
        int unsigned aid;
        int unsigned wi;
        int unsigned si;
        if (mon_en) begin
            exp_hit = 1'b0;
            foreach (pend_line[i]) begin
                if (pend_line[i] == check_nline_i) begin
                    exp_hit = 1'b1;
                end
            end
            for (int i = 0; i < n_ids; i++) begin
                if (out_valid[i] && out_line[i] == check_nline_i &&
                    !(mem_resp_valid_i && mem_resp_i.id == i)) begin
                    exp_hit = 1'b1;
                end
            end
            expect_equal("check_hit_o", check_hit_o, exp_hit);
            occ = pend_line.size() + out_cnt;
            expect_equal("full_o", full_o, occ == n_entries);
            expect_equal("empty_o", empty_o, occ == 0);
            if (!bp_en) begin
                // Both memory readies high, so only the FSM and the directory hold off a flush
                expect_equal("alloc_ready_o", alloc_ready_o,
                             beats_left == 0 && occ < n_entries);
            end
            if (beats_left > 0) begin
                beats_left--;
            end
            if (full_o || busy_o) begin
                check_true(!alloc_ready_o, "alloc_ready_o high while full or busy");
            end

            expect_equal("ack_o", ack_o, mem_resp_valid_i);
            if (mem_resp_valid_i) begin
                aid = mem_resp_i.id;
                check_true(out_valid[aid], "acknowledgement for an id with no open write");
                expect_equal("ack_nline_o", ack_nline_o, out_line[aid]);
                if (out_valid[aid]) begin
                    out_valid[aid] = 1'b0;
                    out_cnt--;
                end
            end

            // Busy window per line
            if (accept_prev) begin
                check_true(busy_o, "busy_o low in the cycle after a flush was accepted");
            end
            if (busy_o) begin
                busy_run++;
            end else if (busy_run > 0) begin
                check_true(busy_run >= beats_per_line, "busy_o dropped before all beats");
                if (!bp_en) begin
                    expect_equal("busy_o cycles", busy_run, beats_per_line);
                end
                lines_sent++;
                check_true(lines_sent <= lines_accepted, "busy_o high with no flush accepted");
                busy_run = 0;
            end

            if (req_hold) begin
                check_true(mem_req_valid_o, "mem_req_valid_o dropped before the request was taken");
                expect_equal("mem_req_o", mem_req_o, held_req);
            end
            req_hold = mem_req_valid_o && !mem_req_ready_i;
            held_req = mem_req_o;
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (pend_line.size() == 0) begin
                    check_true(1'b0, "memory request with no flush waiting for one");
                end else begin
                    expect_equal("mem_req_o.addr", mem_req_o.addr,
                                 {pend_line[0], {offset_width{1'b0}}});
                    expect_equal("mem_req_o.len", mem_req_o.len, flits_per_line - 1);
                    expect_equal("mem_req_o.cmd", mem_req_o.cmd, MEM_WRITE);
                    rid = mem_req_o.id;
                    check_true(rid < n_entries && !out_valid[rid],
                               "request id out of range or already outstanding");
                    out_valid[rid] = 1'b1;
                    out_line[rid] = pend_line.pop_front();
                    out_cnt++;
                    resp_q.push_back(rid);
                end
            end

            if (flit_hold) begin
                check_true(mem_wdata_valid_o, "mem_wdata_valid_o dropped before the flit was taken");
                expect_equal("mem_wdata_o", mem_wdata_o, held_flit);
            end
            flit_hold = mem_wdata_valid_o && !mem_wdata_ready_i;
            held_flit = mem_wdata_o;
            if (mem_wdata_valid_o && mem_wdata_ready_i) begin
                if (exp_fdata.size() == 0) begin
                    check_true(1'b0, "data flit with no flush waiting for one");
                end else begin
                    expect_equal("mem_wdata_o.data", mem_wdata_o.data, exp_fdata.pop_front());
                    expect_equal("mem_wdata_o.last", mem_wdata_o.last, exp_flast.pop_front());
                    if (mem_wdata_o.last) begin
                        check_true(lines_sent > lines_last, "last flit before busy_o dropped");
                        lines_last++;
                    end
                end
            end

            accept_prev = alloc_i && alloc_ready_o;
            if (accept_prev) begin
                wi = alloc_way_i[1];
                si = alloc_nline_i[set_width-1:0];
                pend_line.push_back(alloc_nline_i);
                // First flit carries beats 1:0, second beats 3:2
                exp_fdata.push_back({mem_copy[si][wi][1], mem_copy[si][wi][0]});
                exp_flast.push_back(1'b0);
                exp_fdata.push_back({mem_copy[si][wi][3], mem_copy[si][wi][2]});
                exp_flast.push_back(1'b1);
                hist[hist_ptr] = alloc_nline_i;
                hist_ptr++;
                lines_accepted++;
                beats_left = beats_per_line;
                if (flushes_left > 0) begin
                    flushes_left--;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, flush traffic stalled", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : main
        int start;
        lfsr_q = 32'hc583_035e;
        rst_ni = 1'b0;
        fill_i = '0;
        alloc_i = 1'b0;
        alloc_nline_i = '0;
        alloc_way_i = '0;
        check_nline_i = '0;
        mem_req_ready_i = 1'b0;
        mem_wdata_ready_i = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_i = '0;
        for (int i = 0; i < n_ids; i++) begin
            out_valid[i] = 1'b0;
            out_line[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            hist[i] = '0;
        end

        repeat (8) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        mon_en = 1'b1;
        start = errors;
        @(negedge clk_i);
        check_true(empty_o && !full_o && !busy_o && !ack_o, "status wrong after reset");
        check_true(!mem_req_valid_o && !mem_wdata_valid_o, "memory valid high after reset");
        report_test("reset", 0, start);

        // Load every beat of the data array
        for (int s = 0; s < n_sets; s++) begin
            for (int w = 0; w < n_ways; w++) begin
                for (int b = 0; b < beats_per_line; b++) begin
                    @(posedge clk_i);
                    #2;
                    fill_i.valid = 1'b1;
                    fill_i.set = set_t'(s);
                    fill_i.way_vec = way_vec_t'(1 << w);
                    fill_i.beat = beat_t'(b);
                    fill_i.data = {rand_bits(32), rand_bits(32)};
                    mem_copy[s][w][b] = fill_i.data;
                end
            end
        end
        @(posedge clk_i);
        #2;
        fill_i = '0;
        // Driver starts at the next edge
        @(posedge clk_i);
        drive_en = 1'b1;

        run_flushes("basic", n_basic, 1'b0);

        // Directory full with responses withheld
        start = errors;
        @(posedge clk_i);
        bp_en = 1'b0;
        resp_en = 1'b0;
        flushes_left = n_entries;
        do begin
            @(posedge clk_i);
        end while (flushes_left > 0 || pend_line.size() > 0 || lines_sent != lines_accepted);
        @(negedge clk_i);
        check_true(full_o, "full_o low after filling every directory entry");
        @(posedge clk_i);
        flushes_left = 1;
        repeat (12) begin
            @(negedge clk_i);
            check_true(!alloc_ready_o, "alloc_ready_o high with a full directory");
        end
        @(posedge clk_i);
        flushes_left = 0;
        resp_en = 1'b1;
        wait_drained();
        @(negedge clk_i);
        check_true(empty_o, "empty_o low after the full directory drained");
        report_test("dir_full", n_entries, start);

        run_flushes("back_pressure", n_bp, 1'b1);

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* source/beat_resizer.sv */
`timescale 1ns/1ns

module beat_resizer
    import flush_cfg_pkg::*;
    import flush_mem_pkg::*;
#(
    parameter int unsigned flit_depth = 2
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         w_i,
    input  access_data_t wdata_i,
    input  logic         wlast_i,
    output logic         wok_o,
    input  logic         r_i,
    output logic         rok_o,
    output mem_wdata_t   rdata_o
);

    localparam int unsigned beats_per_flit = mem_data_width / access_width;
    localparam int unsigned sel_width      = $clog2(beats_per_flit);
    localparam int unsigned ptr_width      = $clog2(flit_depth);
    localparam int unsigned cnt_width      = $clog2(flit_depth + 1);

    mem_data_t            asm_q;
    logic [sel_width-1:0] sel_q;
    mem_wdata_t           fifo_q [flit_depth];
    logic [ptr_width-1:0] wr_ptr_q;
    logic [ptr_width-1:0] rd_ptr_q;
    logic [cnt_width-1:0] cnt_q;

    logic       fifo_full;
    logic       beat_w;
    logic       flit_done;
    logic       push;
    logic       pop;
    mem_wdata_t flit;

    assign fifo_full = (cnt_q == cnt_width'(flit_depth));
    assign flit_done = (sel_q == sel_width'(beats_per_flit - 1));

    // Only a beat that closes a flit needs room in the FIFO
    assign wok_o  = ~fifo_full | (w_i & ~flit_done);
    assign beat_w = w_i & wok_o;
    assign push   = beat_w & flit_done;
    assign pop    = r_i & rok_o;

    assign rok_o   = (cnt_q != '0);
    assign rdata_o = fifo_q[rd_ptr_q];

    // Last beat goes on top, earlier beats come from the assembly register
    assign flit.data = {wdata_i, asm_q[mem_data_width-access_width-1:0]};
    assign flit.last = wlast_i;

    always_ff @(posedge clk_i) begin
        if (beat_w && !flit_done) begin
            asm_q[sel_q*access_width +: access_width] <= wdata_i;
        end
        if (push) begin
            fifo_q[wr_ptr_q] <= flit;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sel_q    <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (beat_w) begin
                sel_q <= flit_done ? '0 : sel_q + 1'b1;
            end
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_width'(flit_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_width'(flit_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop && !push) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

endmodule

/* source/flush_cfg_pkg.sv */
package flush_cfg_pkg;

    // Cache geometry
    localparam int unsigned set_width      = 3;
    localparam int unsigned tag_width      = 9;
    localparam int unsigned n_ways         = 2;
    localparam int unsigned beats_per_line = 4;
    localparam int unsigned access_width   = 64;
    localparam int unsigned offset_width   = 5;

    localparam int unsigned n_sets     = 2 ** set_width;
    localparam int unsigned beat_width = $clog2(beats_per_line);

    // Line number, set index in the low bits
    typedef logic [tag_width+set_width-1:0] nline_t;

    typedef logic [set_width-1:0]    set_t;
    typedef logic [n_ways-1:0]       way_vec_t;
    typedef logic [beat_width-1:0]   beat_t;
    typedef logic [access_width-1:0] access_data_t;

    // One beat loaded into the data array
    typedef struct packed {
        logic         valid;
        set_t         set;
        way_vec_t     way_vec;
        beat_t        beat;
        access_data_t data;
    } fill_t;

endpackage

/* source/flush_ctrl.sv */
`timescale 1ns/1ns

module flush_ctrl
    import flush_cfg_pkg::*;
    import flush_mem_pkg::*;
#(
    parameter int unsigned n_entries = 4
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         alloc_i,
    input  nline_t       alloc_nline_i,
    input  way_vec_t     alloc_way_i,
    output logic         alloc_ready_o,
    input  nline_t       check_nline_i,
    output logic         check_hit_o,
    output logic         empty_o,
    output logic         full_o,
    output logic         busy_o,
    output logic         rd_o,
    output set_t         rd_set_o,
    output way_vec_t     rd_way_o,
    output beat_t        rd_beat_o,
    input  access_data_t rd_data_i,
    output logic         rsz_w_o,
    output access_data_t rsz_data_o,
    output logic         rsz_last_o,
    input  logic         rsz_wok_i,
    output logic         meta_w_o,
    output mem_req_t     meta_o,
    input  logic         meta_wok_i,
    input  logic         mem_resp_valid_i,
    input  mem_resp_t    mem_resp_i,
    output logic         ack_o,
    output nline_t       ack_nline_o
);

    localparam int unsigned idx_width = $clog2(n_entries);

    typedef enum logic {
        FLUSH_IDLE,
        FLUSH_SEND
    } flush_fsm_e;

    flush_fsm_e fsm_q, fsm_d;
    beat_t      beat_q, beat_d;
    set_t       set_q;
    way_vec_t   way_q;

    logic [n_entries-1:0] valid_q;
    nline_t               nline_q [n_entries];
    logic [n_entries-1:0] alloc_bv;
    logic [n_entries-1:0] ack_bv;
    logic [n_entries-1:0] match;
    logic [idx_width-1:0] free_ptr;
    logic [idx_width-1:0] ack_ptr;

    logic alloc;
    logic eol;
    set_t alloc_set;

    assign full_o  = &valid_q;
    assign empty_o = ~(|valid_q);
    assign busy_o  = (fsm_q == FLUSH_SEND);

    assign alloc_set = alloc_nline_i[set_width-1:0];
    assign alloc_ready_o = (fsm_q == FLUSH_IDLE) & ~full_o & rsz_wok_i & meta_wok_i;
    assign alloc = alloc_i & alloc_ready_o;

    // Counter wraps to zero once the last beat has been read
    assign eol = (beat_q == '0);

    always_comb begin
        fsm_d      = fsm_q;
        beat_d     = beat_q;
        rd_o       = 1'b0;
        rd_set_o   = set_q;
        rd_way_o   = way_q;
        rd_beat_o  = beat_q;
        rsz_w_o    = 1'b0;
        rsz_last_o = 1'b0;
        unique case (fsm_q)
            FLUSH_IDLE: begin
                if (alloc) begin
                    rd_o      = 1'b1;
                    rd_set_o  = alloc_set;
                    rd_way_o  = alloc_way_i;
                    rd_beat_o = '0;
                    beat_d    = beat_t'(1);
                    fsm_d     = FLUSH_SEND;
                end
            end
            FLUSH_SEND: begin
                rsz_w_o    = 1'b1;
                rsz_last_o = eol;
                // Stall in place while the resizer is full
                if (rsz_wok_i) begin
                    rd_o = ~eol;
                    if (eol) begin
                        fsm_d = FLUSH_IDLE;
                    end else begin
                        beat_d = beat_q + 1'b1;
                    end
                end
            end
            default: fsm_d = FLUSH_IDLE;
        endcase
    end

    assign rsz_data_o = rd_data_i;

    // Metadata enters the FIFO together with the first beat read
    assign meta_w_o    = alloc;
    assign meta_o.addr = {alloc_nline_i, {offset_width{1'b0}}};
    assign meta_o.len  = len_width'(flits_per_line - 1);
    assign meta_o.id   = mem_id_width'(free_ptr);
    assign meta_o.cmd  = MEM_WRITE;

    // Lowest free entry wins
    always_comb begin
        free_ptr = '0;
        for (int i = n_entries - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_ptr = idx_width'(i);
            end
        end
    end

    assign ack_o       = mem_resp_valid_i;
    assign ack_ptr     = idx_width'(mem_resp_i.id);
    assign ack_nline_o = nline_q[ack_ptr];

    for (genvar i = 0; i < n_entries; i++) begin : gen_entry
        assign alloc_bv[i] = alloc & (free_ptr == idx_width'(i));
        assign ack_bv[i]   = mem_resp_valid_i & (ack_ptr == idx_width'(i));
        assign match[i]    = (check_nline_i == nline_q[i]);
    end

    // An entry being acknowledged no longer counts
    assign check_hit_o = |(valid_q & ~ack_bv & match);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fsm_q   <= FLUSH_IDLE;
            beat_q  <= '0;
            valid_q <= '0;
        end else begin
            fsm_q   <= fsm_d;
            beat_q  <= beat_d;
            valid_q <= (valid_q | alloc_bv) & ~ack_bv;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            nline_q[free_ptr] <= alloc_nline_i;
            set_q             <= alloc_set;
            way_q             <= alloc_way_i;
        end
    end

    // Priority pick must land on a free slot, never overwriting a live flush
    a_alloc_free_entry: assert property (
        @(posedge clk_i) disable iff (!rst_ni) alloc |-> !full_o && !valid_q[free_ptr])
        else $error("flush_ctrl allocated over a busy entry");

    // Memory may only acknowledge ids that were issued and are still open
    a_ack_valid_entry: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mem_resp_valid_i |-> (mem_resp_i.id < n_entries) && valid_q[ack_ptr])
        else $error("flush_ctrl ack for idle id %0d", mem_resp_i.id);

endmodule

/* source/flush_mem_pkg.sv */
package flush_mem_pkg;

    // Memory interface widths
    localparam int unsigned mem_data_width = 128;
    localparam int unsigned flits_per_line = 2;
    localparam int unsigned mem_id_width   = 3;
    localparam int unsigned addr_width     = 17;

    localparam int unsigned len_width = $clog2(flits_per_line);

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_cmd_e;

    typedef logic [mem_data_width-1:0] mem_data_t;

    // Request header; len counts flits minus one
    typedef struct packed {
        logic [addr_width-1:0]   addr;
        logic [len_width-1:0]    len;
        logic [mem_id_width-1:0] id;
        mem_cmd_e                cmd;
    } mem_req_t;

    typedef struct packed {
        mem_data_t data;
        logic      last;
    } mem_wdata_t;

    typedef struct packed {
        logic [mem_id_width-1:0] id;
    } mem_resp_t;

endpackage

/* source/flush_unit_top.sv */
`timescale 1ns/1ns

module flush_unit_top
    import flush_cfg_pkg::*;
    import flush_mem_pkg::*;
#(
    parameter int unsigned n_entries  = 4,
    parameter int unsigned flit_depth = 2
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  fill_t      fill_i,
    input  logic       alloc_i,
    input  nline_t     alloc_nline_i,
    input  way_vec_t   alloc_way_i,
    output logic       alloc_ready_o,
    input  nline_t     check_nline_i,
    output logic       check_hit_o,
    output logic       empty_o,
    output logic       full_o,
    output logic       busy_o,
    output logic       ack_o,
    output nline_t     ack_nline_o,
    output logic       mem_req_valid_o,
    input  logic       mem_req_ready_i,
    output mem_req_t   mem_req_o,
    output logic       mem_wdata_valid_o,
    input  logic       mem_wdata_ready_i,
    output mem_wdata_t mem_wdata_o,
    input  logic       mem_resp_valid_i,
    input  mem_resp_t  mem_resp_i
);

    logic         rd;
    set_t         rd_set;
    way_vec_t     rd_way;
    beat_t        rd_beat;
    access_data_t rd_data;
    logic         rsz_w;
    access_data_t rsz_data;
    logic         rsz_last;
    logic         rsz_wok;
    logic         meta_w;
    mem_req_t     meta;
    logic         meta_wok;

    line_data_ram i_line_data_ram (
        .clk_i     (clk_i),
        .fill_i    (fill_i),
        .rd_i      (rd),
        .rd_set_i  (rd_set),
        .rd_way_i  (rd_way),
        .rd_beat_i (rd_beat),
        .rd_data_o (rd_data)
    );

    flush_ctrl #(
        .n_entries (n_entries)
    ) i_flush_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .alloc_i          (alloc_i),
        .alloc_nline_i    (alloc_nline_i),
        .alloc_way_i      (alloc_way_i),
        .alloc_ready_o    (alloc_ready_o),
        .check_nline_i    (check_nline_i),
        .check_hit_o      (check_hit_o),
        .empty_o          (empty_o),
        .full_o           (full_o),
        .busy_o           (busy_o),
        .rd_o             (rd),
        .rd_set_o         (rd_set),
        .rd_way_o         (rd_way),
        .rd_beat_o        (rd_beat),
        .rd_data_i        (rd_data),
        .rsz_w_o          (rsz_w),
        .rsz_data_o       (rsz_data),
        .rsz_last_o       (rsz_last),
        .rsz_wok_i        (rsz_wok),
        .meta_w_o         (meta_w),
        .meta_o           (meta),
        .meta_wok_i       (meta_wok),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_i       (mem_resp_i),
        .ack_o            (ack_o),
        .ack_nline_o      (ack_nline_o)
    );

    beat_resizer #(
        .flit_depth (flit_depth)
    ) i_beat_resizer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (rsz_w),
        .wdata_i (rsz_data),
        .wlast_i (rsz_last),
        .wok_o   (rsz_wok),
        .r_i     (mem_wdata_ready_i),
        .rok_o   (mem_wdata_valid_o),
        .rdata_o (mem_wdata_o)
    );

    req_meta_fifo i_req_meta_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (meta_w),
        .wdata_i (meta),
        .wok_o   (meta_wok),
        .r_i     (mem_req_ready_i),
        .rok_o   (mem_req_valid_o),
        .rdata_o (mem_req_o)
    );

endmodule

/* source/line_data_ram.sv */
`timescale 1ns/1ns

module line_data_ram
    import flush_cfg_pkg::*;
(
    input  logic         clk_i,
    input  fill_t        fill_i,
    input  logic         rd_i,
    input  set_t         rd_set_i,
    input  way_vec_t     rd_way_i,
    input  beat_t        rd_beat_i,
    output access_data_t rd_data_o
);

    access_data_t data_q [n_sets][n_ways][beats_per_line];
    access_data_t rd_sel;

    // Fill port, one beat per cycle
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < n_ways; w++) begin
            if (fill_i.valid && fill_i.way_vec[w]) begin
                data_q[fill_i.set][w][fill_i.beat] <= fill_i.data;
            end
        end
    end

    // Way select by one-hot vector
    always_comb begin
        rd_sel = '0;
        for (int w = 0; w < n_ways; w++) begin
            if (rd_way_i[w]) begin
                rd_sel = rd_sel | data_q[rd_set_i][w][rd_beat_i];
            end
        end
    end

    // Output holds its value between reads
    always_ff @(posedge clk_i) begin
        if (rd_i) begin
            rd_data_o <= rd_sel;
        end
    end

    // The controller must hand over exactly one way per read
    a_rd_way_onehot: assert property (@(posedge clk_i) rd_i |-> $onehot(rd_way_i))
        else $error("line_data_ram read with way vector %b", rd_way_i);

endmodule

/* source/req_meta_fifo.sv */
`timescale 1ns/1ns

module req_meta_fifo
    import flush_mem_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     w_i,
    input  mem_req_t wdata_i,
    output logic     wok_o,
    input  logic     r_i,
    output logic     rok_o,
    output mem_req_t rdata_o
);

    mem_req_t   slot_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] cnt_q;
    logic       push;
    logic       pop;

    assign wok_o   = (cnt_q != 2'd2);
    assign rok_o   = (cnt_q != 2'd0);
    assign rdata_o = slot_q[rd_ptr_q];

    assign push = w_i & wok_o;
    assign pop  = r_i & rok_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            // Simultaneous push and pop keep the count
            if (push && !pop) begin
                cnt_q <= cnt_q + 2'd1;
            end else if (pop && !push) begin
                cnt_q <= cnt_q - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            slot_q[wr_ptr_q] <= wdata_i;
        end
    end

    a_no_write_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni) w_i |-> wok_o)
        else $error("req_meta_fifo written while full");

endmodule
